/* rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width of the core
`define RV_XLEN 32

// Program counter after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* rv_pkg.sv */
package rv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    // Operations of the execute stage ALU
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5
    } alu_op_e;

endpackage

/* rv_if.sv */
`include "rv_config.svh"

// Decoded item, registered in decode and consumed by execute
interface dec_exe_if;
    logic                valid;
    rv_pkg::alu_op_e     alu_op;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [4:0]          rd_ptr;
    logic                reg_we;
    logic                mem_we;
    logic                mem_re;
    logic                is_branch;
    logic [`RV_XLEN-1:0] branch_target;

    modport dec (
        output valid, alu_op, op_a, op_b, rs2_val, rd_ptr,
        output reg_we, mem_we, mem_re, is_branch, branch_target
    );

    modport exe (
        input valid, alu_op, op_a, op_b, rs2_val, rd_ptr,
        input reg_we, mem_we, mem_re, is_branch, branch_target
    );
endinterface

// Memory request from execute, answered by the LSU
interface exe_lsu_if;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic                we;
    logic                re;
    logic [`RV_XLEN-1:0] rdata;
    logic                stall;

    modport exe (output addr, wdata, we, re, input rdata, stall);
    modport lsu (input addr, wdata, we, re, output rdata, stall);
endinterface

/* regfile.sv */
`include "rv_config.svh"

module regfile (
    input  logic                i_CLK,
    input  logic                i_RSTn,
    input  logic [4:0]          i_rs1_ptr,
    input  logic [4:0]          i_rs2_ptr,
    input  logic [4:0]          i_rd_ptr,
    input  logic [`RV_XLEN-1:0] i_rd,
    input  logic                i_we,
    output logic [`RV_XLEN-1:0] o_rs1,
    output logic [`RV_XLEN-1:0] o_rs2
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:31];

    // A read of the register being written returns the new value
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] ptr);
        logic [`RV_XLEN-1:0] val;
        if (ptr == 5'd0) begin
            val = '0;
        end else if (i_we && (ptr == i_rd_ptr)) begin
            val = i_rd;
        end else begin
            val = regs[ptr];
        end
        return val;
    endfunction

    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd_ptr != 5'd0)) begin
            regs[i_rd_ptr] <= i_rd;
        end
    end

    always_comb begin
        o_rs1 = read_port(i_rs1_ptr);
        o_rs2 = read_port(i_rs2_ptr);
    end

endmodule

/* decode.sv */
`include "rv_config.svh"

module decode (
    input  logic                i_CLK,
    input  logic                i_RSTn,
    input  logic [`RV_XLEN-1:0] i_INSTRUCTION,
    input  logic                i_stall,
    input  logic                i_redirect,
    input  logic [`RV_XLEN-1:0] i_redirect_pc,
    input  logic [`RV_XLEN-1:0] i_wb_rd,
    input  logic [4:0]          i_wb_rd_ptr,
    input  logic                i_wb_we,
    output logic [`RV_XLEN-1:0] o_PC,
    dec_exe_if.dec              de
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] word_pc;
    logic [`RV_XLEN-1:0] hold_word;
    logic                hold_valid;
    logic                squash_next;
    logic [`RV_XLEN-1:0] word;
    rv_pkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    rv_pkg::alu_op_e     alu_op;
    logic                use_imm;
    logic                legal;
    logic                reg_we;
    logic                mem_we;
    logic                mem_re;
    logic                is_branch;
    logic                dec_valid;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            pc_q <= `RV_RESET_PC;
        end else if (i_redirect) begin
            pc_q <= i_redirect_pc;
        end else if (!i_stall) begin
            pc_q <= pc_q + `RV_XLEN'd4;
        end
    end

    assign o_PC = pc_q;

    // The word in decode always belongs to the PC shown one fetch earlier
    assign word_pc = pc_q - `RV_XLEN'd4;

    // Keep the word of the first stalled cycle, the bus overwrites it next edge
    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= i_stall;
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_stall && !hold_valid) begin
            hold_word <= i_INSTRUCTION;
        end
    end

    assign word = hold_valid ? hold_word : i_INSTRUCTION;

    // One more word to drop after reset or a taken branch
    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            squash_next <= 1'b1;
        end else if (i_redirect) begin
            squash_next <= 1'b1;
        end else if (!i_stall) begin
            squash_next <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode and register read
    ////////////////////////////////////////////////////////////

    assign opcode = rv_pkg::opcode_e'(word[6:0]);
    assign funct3 = word[14:12];
    assign imm_i  = {{20{word[31]}}, word[31:20]};
    assign imm_s  = {{20{word[31]}}, word[31:25], word[11:7]};
    assign imm_b  = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u  = {word[31:12], 12'b0};

    always_comb begin
        alu_op    = rv_pkg::ADD;
        use_imm   = 1'b1;
        imm       = imm_i;
        legal     = 1'b0;
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            rv_pkg::OP: begin
                use_imm = 1'b0;
                reg_we  = 1'b1;
                legal   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = word[30] ? rv_pkg::SUB : rv_pkg::ADD;
                    3'b100:  alu_op = rv_pkg::XOR;
                    3'b110:  alu_op = rv_pkg::OR;
                    3'b111:  alu_op = rv_pkg::AND;
                    default: legal = 1'b0;
                endcase
            end
            rv_pkg::OP_IMM: begin
                reg_we = 1'b1;
                legal  = (funct3 == 3'b000);
            end
            rv_pkg::LUI: begin
                alu_op = rv_pkg::PASS_B;
                imm    = imm_u;
                reg_we = 1'b1;
                legal  = 1'b1;
            end
            rv_pkg::LOAD: begin
                reg_we = 1'b1;
                mem_re = 1'b1;
                legal  = (funct3 == 3'b010);
            end
            rv_pkg::STORE: begin
                imm    = imm_s;
                mem_we = 1'b1;
                legal  = (funct3 == 3'b010);
            end
            rv_pkg::BRANCH: begin
                // BEQ compares rs1 against rs2 in execute
                use_imm   = 1'b0;
                is_branch = 1'b1;
                legal     = (funct3 == 3'b000);
            end
            default: legal = 1'b0;
        endcase
    end

    // Unsupported encodings pass through as bubbles
    assign dec_valid = legal & ~squash_next & ~i_redirect;

    regfile u_regfile (
        .i_CLK     (i_CLK),
        .i_RSTn    (i_RSTn),
        .i_rs1_ptr (word[19:15]),
        .i_rs2_ptr (word[24:20]),
        .i_rd_ptr  (i_wb_rd_ptr),
        .i_rd      (i_wb_rd),
        .i_we      (i_wb_we),
        .o_rs1     (rs1_val),
        .o_rs2     (rs2_val)
    );

    ////////////////////////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            de.valid <= 1'b0;
        end else if (!i_stall) begin
            de.valid <= dec_valid;
        end
    end

    always_ff @(posedge i_CLK) begin
        if (!i_stall) begin
            de.alu_op        <= alu_op;
            de.op_a          <= rs1_val;
            de.op_b          <= use_imm ? imm : rs2_val;
            de.rs2_val       <= rs2_val;
            de.rd_ptr        <= word[11:7];
            de.reg_we        <= reg_we;
            de.mem_we        <= mem_we;
            de.mem_re        <= mem_re;
            de.is_branch     <= is_branch;
            de.branch_target <= word_pc + imm_b;
        end
    end

endmodule

/* execute.sv */
`include "rv_config.svh"

module execute (
    input  logic                i_stall,
    dec_exe_if.exe              de,
    exe_lsu_if.exe              mem,
    output logic [`RV_XLEN-1:0] o_wb_rd,
    output logic [4:0]          o_wb_rd_ptr,
    output logic                o_wb_we,
    output logic                o_redirect,
    output logic [`RV_XLEN-1:0] o_redirect_pc
);

    logic [`RV_XLEN-1:0] alu_res;
    logic                taken;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (de.alu_op)
            rv_pkg::ADD:    alu_res = de.op_a + de.op_b;
            rv_pkg::SUB:    alu_res = de.op_a - de.op_b;
            rv_pkg::AND:    alu_res = de.op_a & de.op_b;
            rv_pkg::OR:     alu_res = de.op_a | de.op_b;
            rv_pkg::XOR:    alu_res = de.op_a ^ de.op_b;
            rv_pkg::PASS_B: alu_res = de.op_b;
            default:        alu_res = de.op_a + de.op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////

    // Loads and stores decode to ADD, so the ALU forms rs1 + offset
    assign mem.addr  = alu_res;
    assign mem.wdata = de.rs2_val;
    assign mem.we    = de.valid & de.mem_we;
    assign mem.re    = de.valid & de.mem_re;

    ////////////////////////////////////////////////////////////
    // Writeback and branch
    ////////////////////////////////////////////////////////////

    assign o_wb_rd     = de.mem_re ? mem.rdata : alu_res;
    assign o_wb_rd_ptr = de.rd_ptr;

    // Held back until the bus grants, so a load writes its real data
    assign o_wb_we     = de.valid & de.reg_we & ~i_stall;

    // BEQ only
    assign taken         = de.valid & de.is_branch & (de.op_a == de.op_b);
    assign o_redirect    = taken & ~i_stall;
    assign o_redirect_pc = de.branch_target;

endmodule

/* lsu.sv */
`include "rv_config.svh"

module lsu (
    exe_lsu_if.lsu              mem,
    input  logic                i_BUS_GNT,
    input  logic [`RV_XLEN-1:0] i_BUS_RDATA,
    output logic [`RV_XLEN-1:0] o_BUS_ADDR,
    output logic [`RV_XLEN-1:0] o_BUS_WDATA,
    output logic                o_BUS_WE,
    output logic                o_BUS_RE,
    output logic                o_BUS_REQ
);

    logic req;

    // Request stays up as a level until the grant arrives
    assign req = mem.we | mem.re;

    assign o_BUS_ADDR  = mem.addr;
    assign o_BUS_WDATA = mem.we ? mem.wdata : '0;
    assign o_BUS_WE    = mem.we;
    assign o_BUS_RE    = mem.re;
    assign o_BUS_REQ   = req;

    // Whole core waits while the slave has not granted
    assign mem.stall = req & ~i_BUS_GNT;

    // Read data is valid in the grant cycle
    assign mem.rdata = i_BUS_RDATA;

endmodule

/* core.sv */
`include "rv_config.svh"

module core (
    input  logic                i_CLK,
    input  logic                i_RSTn,
    input  logic [`RV_XLEN-1:0] i_INSTRUCTION,
    input  logic [`RV_XLEN-1:0] i_BUS_RDATA,
    input  logic                i_BUS_GNT,
    output logic [`RV_XLEN-1:0] o_PC,
    output logic [`RV_XLEN-1:0] o_BUS_WDATA,
    output logic [`RV_XLEN-1:0] o_BUS_ADDR,
    output logic                o_BUS_WE,
    output logic                o_BUS_RE,
    output logic                o_BUS_REQ
);

    dec_exe_if u_dec_exe ();
    exe_lsu_if u_exe_lsu ();

    // Writeback and redirect back into decode
    logic [`RV_XLEN-1:0] wb_rd;
    logic [4:0]          wb_rd_ptr;
    logic                wb_we;
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    decode u_decode (
        .i_CLK         (i_CLK),
        .i_RSTn        (i_RSTn),
        .i_INSTRUCTION (i_INSTRUCTION),
        .i_stall       (u_exe_lsu.stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_wb_rd       (wb_rd),
        .i_wb_rd_ptr   (wb_rd_ptr),
        .i_wb_we       (wb_we),
        .o_PC          (o_PC),
        .de            (u_dec_exe.dec)
    );

    execute u_execute (
        .i_stall       (u_exe_lsu.stall),
        .de            (u_dec_exe.exe),
        .mem           (u_exe_lsu.exe),
        .o_wb_rd       (wb_rd),
        .o_wb_rd_ptr   (wb_rd_ptr),
        .o_wb_we       (wb_we),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    lsu u_lsu (
        .mem         (u_exe_lsu.lsu),
        .i_BUS_GNT   (i_BUS_GNT),
        .i_BUS_RDATA (i_BUS_RDATA),
        .o_BUS_ADDR  (o_BUS_ADDR),
        .o_BUS_WDATA (o_BUS_WDATA),
        .o_BUS_WE    (o_BUS_WE),
        .o_BUS_RE    (o_BUS_RE),
        .o_BUS_REQ   (o_BUS_REQ)
    );

endmodule

/* core_assertions.sv */
`include "rv_config.svh"

module core_assertions (
    input logic                i_CLK,
    input logic                i_RSTn,
    input logic [`RV_XLEN-1:0] o_BUS_ADDR,
    input logic [`RV_XLEN-1:0] o_BUS_WDATA,
    input logic                o_BUS_WE,
    input logic                o_BUS_RE,
    input logic                o_BUS_REQ,
    input logic                i_BUS_GNT
);

    int fail_count;

    initial fail_count = 0;

    // Request waits with a frozen address, data and direction
    req_stable: assert property (@(posedge i_CLK) disable iff (!i_RSTn)
        o_BUS_REQ && !i_BUS_GNT |=> o_BUS_REQ && $stable(o_BUS_ADDR) &&
        $stable(o_BUS_WDATA) && $stable(o_BUS_WE) && $stable(o_BUS_RE))
        else begin
            $error("bus request changed while waiting for grant");
            fail_count++;
        end

    we_needs_req: assert property (@(posedge i_CLK) disable iff (!i_RSTn)
        o_BUS_WE |-> o_BUS_REQ)
        else begin
            $error("write enable without request");
            fail_count++;
        end

    // One reset edge is needed before the pipeline register is cleared
    no_req_in_reset: assert property (@(posedge i_CLK)
        !i_RSTn ##1 !i_RSTn |-> !o_BUS_REQ)
        else begin
            $error("bus request during reset");
            fail_count++;
        end

endmodule

bind core core_assertions u_core_assertions (.*);

/* core_checker.sv */
`include "rv_config.svh"

module core_checker (
    input  logic                i_CLK,
    input  logic                i_RSTn,
    input  logic [`RV_XLEN-1:0] i_PC,
    input  logic [`RV_XLEN-1:0] i_INSTRUCTION,
    input  logic [`RV_XLEN-1:0] i_BUS_ADDR,
    input  logic [`RV_XLEN-1:0] i_BUS_WDATA,
    input  logic                i_BUS_WE,
    input  logic                i_BUS_REQ,
    input  logic                i_BUS_GNT,
    input  logic [`RV_XLEN-1:0] i_exp_addr [0:31],
    input  logic [`RV_XLEN-1:0] i_exp_data [0:31],
    input  int                  i_exp_count,
    output int                  o_store_count,
    output int                  o_error_count
);

    logic            first_cycle;
    logic            mem_fetched;
    rv_pkg::opcode_e op;

    assign op = rv_pkg::opcode_e'(i_INSTRUCTION[6:0]);

    initial begin
        o_store_count = 0;
        o_error_count = 0;
        first_cycle   = 1'b0;
        mem_fetched   = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // Reset behavior
    ////////////////////////////////////////////////////////////

    always @(posedge i_CLK) begin
        if (!i_RSTn) begin
            first_cycle <= 1'b1;
            mem_fetched <= 1'b0;
        end else begin
            first_cycle <= 1'b0;
            if (first_cycle && (i_PC !== `RV_RESET_PC)) begin
                $display("CHECK FAILED at %0t: PC after reset is %h", $time, i_PC);
                o_error_count = o_error_count + 1;
            end
            // No request before any load or store has even been fetched
            if (i_BUS_REQ !== 1'b0 && !mem_fetched) begin
                $display("CHECK FAILED at %0t: bus request before any load or store", $time);
                o_error_count = o_error_count + 1;
            end
            // The word of the first cycle is dropped by decode
            if (!first_cycle && (op == rv_pkg::LOAD || op == rv_pkg::STORE)) begin
                mem_fetched <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Store sequence
    ////////////////////////////////////////////////////////////

    always @(posedge i_CLK) begin
        if (i_RSTn && i_BUS_WE && i_BUS_REQ && i_BUS_GNT) begin
            if (o_store_count >= i_exp_count) begin
                $display("ERROR: more stores than expected, extra store to %h", i_BUS_ADDR);
                o_error_count = o_error_count + 1;
            end else if (i_BUS_ADDR !== i_exp_addr[o_store_count] ||
                         i_BUS_WDATA !== i_exp_data[o_store_count]) begin
                $display("CHECK FAILED at %0t: store %0d got %h <= %h, expected %h <= %h",
                         $time, o_store_count, i_BUS_ADDR, i_BUS_WDATA,
                         i_exp_addr[o_store_count], i_exp_data[o_store_count]);
                o_error_count = o_error_count + 1;
            end
            o_store_count <= o_store_count + 1;
        end
    end

    task automatic check_end();
        if (o_store_count < i_exp_count) begin
            $display("ERROR: missing stores at end, saw %0d of %0d",
                     o_store_count, i_exp_count);
            o_error_count = o_error_count + 1;
        end
    endtask

endmodule

/* core_tb.sv */
`include "rv_config.svh"

module core_tb;

    localparam int RST_CYCLES = 16;

    logic                i_CLK;
    logic                i_RSTn;
    logic [`RV_XLEN-1:0] i_INSTRUCTION;
    logic [`RV_XLEN-1:0] i_BUS_RDATA;
    logic                i_BUS_GNT;
    logic [`RV_XLEN-1:0] o_PC;
    logic [`RV_XLEN-1:0] o_BUS_WDATA;
    logic [`RV_XLEN-1:0] o_BUS_ADDR;
    logic                o_BUS_WE;
    logic                o_BUS_RE;
    logic                o_BUS_REQ;

    logic [31:0]         golden [0:255];
    logic [31:0]         prog [0:47];
    logic [31:0]         dmem [0:63];
    logic [`RV_XLEN-1:0] exp_addr [0:31];
    logic [`RV_XLEN-1:0] exp_data [0:31];
    int                  prog_len;
    int                  exp_count;
    int                  store_count;
    int                  error_count;
    logic [31:0]         lfsr;
    logic [1:0]          wait_left;

    core u_core (.*);

    core_checker u_checker (
        .i_CLK         (i_CLK),
        .i_RSTn        (i_RSTn),
        .i_PC          (o_PC),
        .i_INSTRUCTION (i_INSTRUCTION),
        .i_BUS_ADDR    (o_BUS_ADDR),
        .i_BUS_WDATA   (o_BUS_WDATA),
        .i_BUS_WE      (o_BUS_WE),
        .i_BUS_REQ     (o_BUS_REQ),
        .i_BUS_GNT     (i_BUS_GNT),
        .i_exp_addr    (exp_addr),
        .i_exp_data    (exp_data),
        .i_exp_count   (exp_count),
        .o_store_count (store_count),
        .o_error_count (error_count)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial i_CLK = 1'b0;
    always #20 i_CLK = ~i_CLK;

    ////////////////////////////////////////////////////////////
    // Instruction and data memory model
    ////////////////////////////////////////////////////////////

    always @(posedge i_CLK) begin
        if ((o_PC >> 2) < prog_len) begin
            i_INSTRUCTION <= prog[o_PC >> 2];
        end else begin
            i_INSTRUCTION <= '0;
        end
    end

    assign i_BUS_RDATA = (o_BUS_RE && i_BUS_GNT) ? dmem[o_BUS_ADDR[7:2]] : '0;

    // Grant is a level that drops for 0 to 3 cycles after each access
    always @(posedge i_CLK) begin
        logic [31:0] s;
        if (!i_RSTn) begin
            wait_left <= 2'd0;
            i_BUS_GNT <= 1'b1;
        end else if (o_BUS_REQ && i_BUS_GNT) begin
            if (o_BUS_WE) begin
                dmem[o_BUS_ADDR[7:2]] <= o_BUS_WDATA;
            end
            s = lfsr_step(lfsr);
            s = lfsr_step(s);
            lfsr      <= s;
            wait_left <= s[1:0];
            i_BUS_GNT <= (s[1:0] == 2'd0);
        end else if (wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
            i_BUS_GNT <= (wait_left == 2'd1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        $readmemh("core_golden.txt", golden);
        prog_len  = golden[0];
        exp_count = golden[1];
        for (int i = 0; i < 48; i++) begin
            prog[i] = (i < prog_len) ? golden[16 + i] : 32'h0;
        end
        // Filler ties each word to its own index
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hdead_0000 | (i << 2);
        end
        for (int i = 0; i < golden[2]; i++) begin
            dmem[i] = golden[64 + i];
        end
        for (int i = 0; i < 32; i++) begin
            exp_addr[i] = golden[80 + 2 * i];
            exp_data[i] = golden[81 + 2 * i];
        end
        lfsr          = 32'h249c_996e;
        i_RSTn        = 1'b0;
        i_INSTRUCTION = '0;
        i_BUS_GNT     = 1'b1;
        repeat (RST_CYCLES) @(posedge i_CLK);
        i_RSTn <= 1'b1;
        while (store_count < exp_count) begin
            @(posedge i_CLK);
        end
        // Room for any stray store after the last expected one
        repeat (8) @(posedge i_CLK);
        $display("Stores seen: %0d of %0d, errors: %0d, assertion failures: %0d",
                 store_count, exp_count, error_count,
                 u_core.u_core_assertions.fail_count);
        if (error_count == 0 && u_core.u_core_assertions.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        @(posedge i_CLK);
        repeat (prog_len * 8 + RST_CYCLES) @(posedge i_CLK);
        $display("Timeout: program did not produce all expected stores in time");
        u_checker.check_end();
        #1;
        $display("Stores seen: %0d of %0d, errors: %0d, assertion failures: %0d",
                 store_count, exp_count, error_count,
                 u_core.u_core_assertions.fail_count);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* core_golden.txt */
// Header: program length, expected store count, initial data word count
// Then @010 program words, @040 initial data memory, @050 expected (address, data) pairs
@000
0000001c 0000000b 00000004
@010
00002083 00402103 002081b3 08302023
40208233 08402223 0020f2b3 08502423
0020e333 08602623 0020c3b3 08702823
fff08413 08802a23 abcde4b7 08902c23
00802503 00550593 08b02e23 00a50663
0a102023 0a202223 0aa02423 00208463
0ab02623 08002603 0ac02823 00000063
@040
12345678 0f0f00ff 00000003 a5a5a5a5
@050
00000080 21435777
00000084 03255579
00000088 02040078
0000008c 1f3f56ff
00000090 1d3b5687
00000094 12345677
00000098 abcde000
0000009c 00000008
000000a8 00000003
000000ac 00000008
000000b0 21435777

/* src.f */
+incdir+.
rv_pkg.sv
rv_if.sv
regfile.sv
decode.sv
execute.sv
lsu.sv
core.sv
core_assertions.sv
core_checker.sv
core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_pkg.sv
  - rv_if.sv
  - regfile.sv
  - decode.sv
  - execute.sv
  - lsu.sv
  - core.sv
  - target: test
    files:
      - core_assertions.sv
      - core_checker.sv
      - core_tb.sv
